// ==== hw/mtx_sig_macros.svh ====
`ifndef MTX_SIG_MACROS_SVH
`define MTX_SIG_MACROS_SVH

// datapath widths
`define MTX_PHASE_W      24
`define MTX_SAMPLE_W     16
`define MTX_LUT_ADDR_W   8
`define MTX_CNT_W        16

// frame geometry, kept small for simulation
`define MTX_NSIG         16
`define MTX_NSYMB        4

// location counter, sync while it reads all ones
`define MTX_LOC_W        2

// phase program of the stepped chirp
`define MTX_START_PH     24'h000000
`define MTX_START_PH_INC 24'h080000
`define MTX_DPH_INC      24'h010000
`define MTX_NPH_SHIFT    24'h001000

`endif

// ==== hw/mtx_sig_pkg.sv ====
`include "mtx_sig_macros.svh"

package mtx_sig_pkg;

  // unsigned phase word, full turn = 2**MTX_PHASE_W
  typedef logic [`MTX_PHASE_W-1:0] phase_t;

  typedef logic signed [`MTX_SAMPLE_W-1:0] sample_t;

  // sideband travelling with every beat
  typedef struct packed {
    logic last;  // final sample of a symbol
    logic sync;  // frame with all-ones location count
  } side_t;

  typedef struct packed {
    phase_t phase;
    side_t  side;
  } phase_beat_t;

  typedef struct packed {
    sample_t sin;
    sample_t cos;
    side_t   side;
  } iq_beat_t;

endpackage

// ==== hw/stream_stage.sv ====
`timescale 1ns/100ps

module stream_stage
  import mtx_sig_pkg::*;
#(
  parameter type payload_t = phase_beat_t
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     srst,
  input  logic     in_valid,
  input  payload_t in_data,
  input  logic     out_ready,
  output logic     in_ready,
  output logic     out_valid,
  output payload_t out_data
);

  // slot frees up in the same cycle it is drained
  assign in_ready = !out_valid || out_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else if (srst) begin
      out_valid <= 1'b0;
    end else if (in_ready) begin
      out_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      out_data <= in_data;  // payload only
    end
  end

  a_data_hold: assert property (
    @(posedge clk) disable iff (!rst_n || srst)
    out_valid && !out_ready |=> out_valid && $stable(out_data)
  );

endmodule

// ==== hw/mtx_phase_seq.sv ====
`timescale 1ns/100ps
`include "mtx_sig_macros.svh"

module mtx_phase_seq
  import mtx_sig_pkg::*;
#(
  parameter int unsigned NSIG  = `MTX_NSIG,
  parameter int unsigned NSYMB = `MTX_NSYMB,
  parameter int unsigned LOC_W = `MTX_LOC_W
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   srst,
  input  logic   run,
  input  logic   phase_ready,
  output logic   phase_valid,
  output phase_t phase,
  output logic   phase_last,
  output logic   phase_sync
);

  localparam int unsigned CNT_W = `MTX_CNT_W;
  localparam logic [CNT_W-1:0] LAST_SIG  = CNT_W'(NSIG);
  localparam logic [CNT_W-1:0] LAST_SYMB = CNT_W'(NSYMB);
  localparam logic FIRST_LAST = (NSIG == 1);  // one-sample symbols

  localparam phase_t START_PH     = `MTX_START_PH;
  localparam phase_t START_PH_INC = `MTX_START_PH_INC;
  localparam phase_t DPH_INC      = `MTX_DPH_INC;
  localparam phase_t NPH_SHIFT    = `MTX_NPH_SHIFT;

  logic [CNT_W-1:0] sample_cnt;  // 1..NSIG
  logic [CNT_W-1:0] symb_cnt;    // 1..NSYMB
  phase_t           phase_inc;
  phase_t           start_ph;    // start of the next symbol
  logic [LOC_W-1:0] loc_cnt;     // completed frames
  logic [LOC_W-1:0] loc_nxt;
  logic             xfer;

  assign xfer    = phase_valid && phase_ready;
  assign loc_nxt = loc_cnt + 1'b1;

  // valid follows run but never drops under a pending beat
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_valid <= 1'b0;
    end else if (srst) begin
      phase_valid <= 1'b0;
    end else if (!phase_valid || phase_ready) begin
      phase_valid <= run;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase      <= START_PH;
      phase_inc  <= START_PH_INC;
      start_ph   <= START_PH - NPH_SHIFT;
      sample_cnt <= CNT_W'(1);
      symb_cnt   <= CNT_W'(1);
      loc_cnt    <= '0;
      phase_last <= FIRST_LAST;
      phase_sync <= 1'b0;
    end else if (srst) begin
      phase      <= START_PH;
      phase_inc  <= START_PH_INC;
      start_ph   <= START_PH - NPH_SHIFT;
      sample_cnt <= CNT_W'(1);
      symb_cnt   <= CNT_W'(1);
      loc_cnt    <= '0;
      phase_last <= FIRST_LAST;
      phase_sync <= 1'b0;
    end else if (xfer) begin
      if (sample_cnt == LAST_SIG) begin
        sample_cnt <= CNT_W'(1);
        phase_last <= FIRST_LAST;
        if (symb_cnt == LAST_SYMB) begin
          // frame done, back to the initial chirp
          symb_cnt   <= CNT_W'(1);
          phase      <= START_PH;
          phase_inc  <= START_PH_INC;
          start_ph   <= START_PH - NPH_SHIFT;
          loc_cnt    <= loc_nxt;
          phase_sync <= &loc_nxt;
        end else begin
          symb_cnt  <= symb_cnt + 1'b1;
          phase     <= start_ph;
          phase_inc <= phase_inc + DPH_INC;  // frequency step
          start_ph  <= start_ph - NPH_SHIFT;
        end
      end else begin
        sample_cnt <= sample_cnt + 1'b1;
        phase      <= phase + phase_inc;
        phase_last <= (sample_cnt + 1'b1 == LAST_SIG);
      end
    end
  end

  // a stalled beat must not move
  a_phase_hold: assert property (
    @(posedge clk) disable iff (!rst_n || srst)
    phase_valid && !phase_ready |=> phase_valid && $stable(phase)
  );

  a_cnt_range: assert property (
    @(posedge clk) disable iff (!rst_n)
    sample_cnt >= CNT_W'(1) && sample_cnt <= LAST_SIG
  );

endmodule

// ==== hw/sin_cos_lut.sv ====
`timescale 1ns/100ps
`include "mtx_sig_macros.svh"

module sin_cos_lut
  import mtx_sig_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    srst,
  input  logic    phase_valid,
  input  phase_t  phase,
  input  logic    phase_last,
  input  logic    phase_sync,
  input  logic    out_ready,
  output logic    phase_ready,
  output logic    out_valid,
  output sample_t sin,
  output sample_t cos,
  output logic    out_last,
  output logic    out_sync
);

  localparam int PHASE_W   = `MTX_PHASE_W;
  localparam int ADDR_W    = `MTX_LUT_ADDR_W;
  localparam int MAG_W     = `MTX_SAMPLE_W - 1;
  localparam int LUT_DEPTH = 2 ** ADDR_W;
  localparam real PI       = 3.14159265358979;

  typedef logic [LUT_DEPTH-1:0][MAG_W-1:0] lut_t;

  // quarter wave sampled at half steps, so the mirror needs no edge fixup
  function automatic lut_t build_lut();
    lut_t t;
    real  amp;
    real  x;
    amp = 2.0 ** MAG_W - 1.0;
    for (int k = 0; k < LUT_DEPTH; k++) begin
      x    = amp * $sin(PI / 2.0 * (k + 0.5) / LUT_DEPTH);
      t[k] = MAG_W'($rtoi(x + 0.5));
    end
    return t;
  endfunction

  // sign-magnitude word to two's complement
  function automatic sample_t apply_sign(sample_t sm);
    sample_t m;
    m = {1'b0, sm[MAG_W-1:0]};
    return sm[MAG_W] ? -m : m;
  endfunction

  localparam lut_t LUT = build_lut();

  phase_beat_t       s1_in, s1_out;
  iq_beat_t          s2_in, s2_out;
  iq_beat_t          s3_in, s3_out;
  logic              s1_valid, s2_valid;
  logic              s2_ready, s3_ready;
  logic [1:0]        quad;
  logic [ADDR_W-1:0] sin_addr;
  logic [ADDR_W-1:0] cos_addr;

  assign s1_in.phase     = phase;
  assign s1_in.side.last = phase_last;
  assign s1_in.side.sync = phase_sync;

  stream_stage #(.payload_t(phase_beat_t)) u_reg_phase (
    .clk       (clk),
    .rst_n     (rst_n),
    .srst      (srst),
    .in_valid  (phase_valid),
    .in_data   (s1_in),
    .out_ready (s2_ready),
    .in_ready  (phase_ready),
    .out_valid (s1_valid),
    .out_data  (s1_out)
  );

  // quadrant folding, odd quadrants run the table backwards
  assign quad     = s1_out.phase[PHASE_W-1 -: 2];
  assign sin_addr = quad[0] ? ~s1_out.phase[PHASE_W-3 -: ADDR_W]
                            : s1_out.phase[PHASE_W-3 -: ADDR_W];
  assign cos_addr = ~sin_addr;

  always_comb begin
    s2_in.sin  = {quad[1], LUT[sin_addr]};            // negative half
    s2_in.cos  = {quad[1] ^ quad[0], LUT[cos_addr]};  // quadrants 1 and 2
    s2_in.side = s1_out.side;
  end

  stream_stage #(.payload_t(iq_beat_t)) u_reg_lut (
    .clk       (clk),
    .rst_n     (rst_n),
    .srst      (srst),
    .in_valid  (s1_valid),
    .in_data   (s2_in),
    .out_ready (s3_ready),
    .in_ready  (s2_ready),
    .out_valid (s2_valid),
    .out_data  (s2_out)
  );

  always_comb begin
    s3_in.sin  = apply_sign(s2_out.sin);
    s3_in.cos  = apply_sign(s2_out.cos);
    s3_in.side = s2_out.side;
  end

  stream_stage #(.payload_t(iq_beat_t)) u_reg_sign (
    .clk       (clk),
    .rst_n     (rst_n),
    .srst      (srst),
    .in_valid  (s2_valid),
    .in_data   (s3_in),
    .out_ready (out_ready),
    .in_ready  (s3_ready),
    .out_valid (out_valid),
    .out_data  (s3_out)
  );

  assign sin      = s3_out.sin;
  assign cos      = s3_out.cos;
  assign out_last = out_valid && s3_out.side.last;  // sideband zero when idle
  assign out_sync = out_valid && s3_out.side.sync;

endmodule

// ==== hw/mtx_sig_top.sv ====
`timescale 1ns/100ps

module mtx_sig_top
  import mtx_sig_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    srst,
  input  logic    run,
  input  logic    out_ready,
  output logic    out_valid,
  output sample_t sin,
  output sample_t cos,
  output logic    out_last,
  output logic    out_sync
);

  // phase stream between sequencer and lookup
  logic   phase_valid;
  logic   phase_ready;
  phase_t phase;
  logic   phase_last;
  logic   phase_sync;

  mtx_phase_seq u_seq (
    .clk         (clk),
    .rst_n       (rst_n),
    .srst        (srst),
    .run         (run),
    .phase_ready (phase_ready),
    .phase_valid (phase_valid),
    .phase       (phase),
    .phase_last  (phase_last),
    .phase_sync  (phase_sync)
  );

  sin_cos_lut u_lut (
    .clk         (clk),
    .rst_n       (rst_n),
    .srst        (srst),
    .phase_valid (phase_valid),
    .phase       (phase),
    .phase_last  (phase_last),
    .phase_sync  (phase_sync),
    .out_ready   (out_ready),
    .phase_ready (phase_ready),
    .out_valid   (out_valid),
    .sin         (sin),
    .cos         (cos),
    .out_last    (out_last),
    .out_sync    (out_sync)
  );

endmodule

// ==== verif/mtx_sig_checker.sv ====
`timescale 1ns/100ps
`include "mtx_sig_macros.svh"

module mtx_sig_checker
  import mtx_sig_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    srst,
  input  logic    run,
  input  logic    out_ready,
  input  logic    out_valid,
  input  sample_t sin,
  input  sample_t cos,
  input  logic    out_last,
  input  logic    out_sync,
  output int      n_xfer,
  output int      n_err
);

  localparam int  NSIG      = `MTX_NSIG;
  localparam int  NSYMB     = `MTX_NSYMB;
  localparam int  IDX_W     = `MTX_LUT_ADDR_W + 2;  // phase bits seen by the table
  localparam int  LOC_MOD   = 1 << `MTX_LOC_W;
  localparam int  FIRST_LAT = 4;                     // phase_valid plus three stages
  localparam real PI        = 3.14159265358979;
  localparam real AMP       = 2.0 ** (`MTX_SAMPLE_W - 1) - 1.0;

  int      xfer_cnt = 0;
  int      err_cnt  = 0;
  int      samp_idx, symb_idx, frame_idx;
  int      lat_cnt;
  logic    lat_armed, lat_on;
  logic    srst_seen, stalled;
  sample_t held_sin, held_cos;
  logic    held_last, held_sync;

  assign n_xfer = xfer_cnt;
  assign n_err  = err_cnt;

  // chirp in closed form, start and step move linearly with the symbol
  function automatic phase_t model_phase(int symb, int samp);
    phase_t start;
    phase_t step;
    start = phase_t'(`MTX_START_PH) - phase_t'(symb) * phase_t'(`MTX_NPH_SHIFT);
    step  = phase_t'(`MTX_START_PH_INC) + phase_t'(symb) * phase_t'(`MTX_DPH_INC);
    return start + phase_t'(samp) * step;
  endfunction

  // ideal value at the centre of the table cell
  function automatic int ideal(phase_t ph, bit want_cos);
    real ang;
    real x;
    ang = 2.0 * PI * ($itor(ph[`MTX_PHASE_W-1 -: IDX_W]) + 0.5) / (2.0 ** IDX_W);
    x   = want_cos ? AMP * $cos(ang) : AMP * $sin(ang);
    return (x >= 0.0) ? $rtoi(x + 0.5) : -$rtoi(0.5 - x);
  endfunction

  function automatic bit within_lsb(sample_t got, int want);
    int d;
    d = int'(got) - want;
    return (d >= -1) && (d <= 1);
  endfunction

  task automatic report_mismatch(string msg);
    err_cnt++;
    $display("MISMATCH at %0t: %s", $time, msg);
  endtask

  task automatic restart_model();
    samp_idx  = 0;
    symb_idx  = 0;
    frame_idx = 0;
  endtask

  task automatic check_beat();
    phase_t ph;
    int     want_sin;
    int     want_cos;
    string  where;
    ph       = model_phase(symb_idx, samp_idx);
    want_sin = ideal(ph, 1'b0);
    want_cos = ideal(ph, 1'b1);
    where    = $sformatf("frame %0d symbol %0d sample %0d",
                         frame_idx, symb_idx, samp_idx);
    if (!within_lsb(sin, want_sin))
      report_mismatch($sformatf("%s sin %0d, expected %0d", where, sin, want_sin));
    if (!within_lsb(cos, want_cos))
      report_mismatch($sformatf("%s cos %0d, expected %0d", where, cos, want_cos));
    if (out_last !== (samp_idx == NSIG - 1))
      report_mismatch($sformatf("%s out_last %b", where, out_last));
    if (out_sync !== (frame_idx % LOC_MOD == LOC_MOD - 1))
      report_mismatch($sformatf("%s out_sync %b", where, out_sync));
    xfer_cnt++;
    if (samp_idx == NSIG - 1) begin
      samp_idx = 0;
      if (symb_idx == NSYMB - 1) begin
        symb_idx = 0;
        frame_idx++;
      end else begin
        symb_idx++;
      end
    end else begin
      samp_idx++;
    end
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      restart_model();
      lat_armed = 1'b1;
      lat_on    = 1'b0;
      srst_seen = 1'b0;
      stalled   = 1'b0;
    end else begin
      if (stalled && (!out_valid || sin !== held_sin || cos !== held_cos ||
                      out_last !== held_last || out_sync !== held_sync))
        report_mismatch("stalled sample changed or dropped before out_ready");
      if (srst_seen && out_valid)
        report_mismatch("out_valid still high one cycle after srst");
      if (out_valid && out_ready)
        check_beat();
      if (lat_on) begin
        lat_cnt++;
        if (out_valid) begin
          lat_on = 1'b0;
          if (lat_cnt != FIRST_LAT)
            report_mismatch($sformatf("first sample %0d cycles after run, expected %0d",
                                      lat_cnt, FIRST_LAT));
        end
      end else if (lat_armed && run && !srst) begin
        lat_armed = 1'b0;  // run seen, pipeline empty
        lat_on    = 1'b1;
        lat_cnt   = 0;
      end
      if (srst) begin
        restart_model();
        lat_armed = 1'b1;
        lat_on    = 1'b0;
      end
      srst_seen = srst;
      stalled   = out_valid && !out_ready && !srst;
      held_sin  = sin;
      held_cos  = cos;
      held_last = out_last;
      held_sync = out_sync;
    end
  end

endmodule

// ==== verif/mtx_sig_tb.sv ====
`timescale 1ns/100ps
`include "mtx_sig_macros.svh"

module mtx_sig_tb
  import mtx_sig_pkg::*;
();

  localparam int FRAME_LEN  = `MTX_NSIG * `MTX_NSYMB;
  localparam int HALF_RUN   = 5 * FRAME_LEN;           // samples on each side of srst
  localparam int MAX_CYCLES = 2 * HALF_RUN * 6 + 160;  // room for stalls and run gaps
  localparam logic [31:0] SEED = 32'hc19da81c;

  typedef enum logic [1:0] {STIM_IDLE, STIM_STEADY, STIM_RANDOM} stim_mode_t;

  logic       clk;
  logic       rst_n;
  logic       srst;
  logic       run;
  logic       out_ready;
  logic       out_valid;
  logic       out_last;
  logic       out_sync;
  sample_t    sin;
  sample_t    cos;
  stim_mode_t stim_mode;
  int         run_gap = 0;  // cycles left in a run low burst
  int         cycles  = 0;
  int         n_xfer;
  int         n_err;
  int         base;

  always #10 clk = ~clk;

  always @(posedge clk) cycles <= cycles + 1;

  always @(posedge clk) begin
    case (stim_mode)
      STIM_IDLE: begin
        run       <= 1'b0;
        out_ready <= 1'b0;
      end
      STIM_STEADY: begin
        run       <= 1'b1;
        out_ready <= 1'b1;
      end
      default: begin
        out_ready <= ($urandom % 100) < 70;  // about 70 % ready
        if (run_gap > 0) begin
          run     <= 1'b0;
          run_gap <= run_gap - 1;
        end else if (($urandom % 100) < 4) begin
          run     <= 1'b0;
          run_gap <= $urandom % 5;
        end else begin
          run <= 1'b1;
        end
      end
    endcase
  end

  mtx_sig_top uut (
    .clk       (clk),
    .rst_n     (rst_n),
    .srst      (srst),
    .run       (run),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .sin       (sin),
    .cos       (cos),
    .out_last  (out_last),
    .out_sync  (out_sync)
  );

  mtx_sig_checker u_chk (
    .clk       (clk),
    .rst_n     (rst_n),
    .srst      (srst),
    .run       (run),
    .out_ready (out_ready),
    .out_valid (out_valid),
    .sin       (sin),
    .cos       (cos),
    .out_last  (out_last),
    .out_sync  (out_sync),
    .n_xfer    (n_xfer),
    .n_err     (n_err)
  );

  initial begin
    void'($urandom(SEED));
    clk       = 1'b0;
    rst_n     = 1'b0;
    srst      = 1'b0;
    run       = 1'b0;
    out_ready = 1'b0;
    stim_mode = STIM_IDLE;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    repeat (2) @(posedge clk);
    stim_mode <= STIM_STEADY;  // first sample latency window
    repeat (40) @(posedge clk);
    stim_mode <= STIM_RANDOM;
    while (n_xfer < HALF_RUN) @(negedge clk);
    @(posedge clk);
    srst      <= 1'b1;
    stim_mode <= STIM_STEADY;
    @(posedge clk);
    srst <= 1'b0;
    @(negedge clk);
    base = n_xfer;
    repeat (40) @(posedge clk);
    stim_mode <= STIM_RANDOM;
    while (n_xfer < base + HALF_RUN) @(negedge clk);
    repeat (4) @(negedge clk);
    $display("errors: %0d, samples checked: %0d, cycles: %0d", n_err, n_xfer, cycles);
    if (n_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    wait (cycles >= MAX_CYCLES);
    $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
    $display("errors: %0d, samples checked: %0d, cycles: %0d", n_err, n_xfer, cycles);
    $display("Something failed");
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+hw
hw/mtx_sig_pkg.sv
hw/stream_stage.sv
hw/mtx_phase_seq.sv
hw/sin_cos_lut.sv
hw/mtx_sig_top.sv
verif/mtx_sig_checker.sv
verif/mtx_sig_tb.sv

// ==== Bender.yml ====
package:
  name: mtx_sig

export_include_dirs:
  - hw

sources:
  - include_dirs:
      - hw
    files:
      - hw/mtx_sig_pkg.sv
      - hw/stream_stage.sv
      - hw/mtx_phase_seq.sv
      - hw/sin_cos_lut.sv
      - hw/mtx_sig_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - verif/mtx_sig_checker.sv
      - verif/mtx_sig_tb.sv
